// ==== memory_map_config.svh ====
`ifndef MEMORY_MAP_CONFIG_SVH
`define MEMORY_MAP_CONFIG_SVH

// Data word shared by RAM, I/O page and both buses
`define MM_DATA_W 18

// RAM depth as address bits, 16K words
`define MM_RAM_AW 14

// CPU side address
`define MM_CPU_AW 16

// Gun channels in the generate loop
`define MM_NUM_GUNS 2

// High address byte selecting the I/O page
`define MM_IO_PAGE 8'hF0

// Edges after a shot during which the sensor counts
`define MM_HIT_WINDOW 16

// Random register, must stay non-zero from reset
`define MM_RAND_W 10
`define MM_LFSR_SEED 1

`endif

// ==== mm_bus_pkg.sv ====
`default_nettype none

`include "memory_map_config.svh"

package mm_bus_pkg;

	// RAM view of a CPU address, region 00 is the RAM
	typedef struct packed {
		logic [`MM_CPU_AW-`MM_RAM_AW-1:0] region;
		logic [`MM_RAM_AW-1:0]            word;
	} ram_addr_t;

	// I/O view, page byte then register code
	typedef struct packed {
		logic [7:0] page;
		logic [7:0] reg_sel;
	} io_addr_t;

	// Same 16 address bits, decoded either way
	typedef union packed {
		ram_addr_t ram;
		io_addr_t  io;
	} mm_addr_u;

	// CPU port request as sampled on the clock edge
	typedef struct packed {
		logic                  wr;
		mm_addr_u              addr;
		logic [`MM_DATA_W-1:0] din;
	} cpu_req_t;

	// Register codes in the I/O page, anything else reads zero
	typedef enum logic [7:0] {
		SEL_GUN0 = 8'h00,
		SEL_GUN1 = 8'h01,
		SEL_RAND = 8'h10
	} io_sel_e;

endpackage

`default_nettype wire

// ==== mm_gun_pkg.sv ====
`default_nettype none

package mm_gun_pkg;

	// Shot and hit counter width, wraps
	localparam int GUN_CNT_W = 8;

	// Synchronized pin levels of one gun
	typedef struct packed {
		logic trigger;
		logic sens;
	} gun_pins_t;

	// Single cycle event pulses
	typedef struct packed {
		logic shot;
		logic hit;
	} gun_event_t;

	// Status word as the CPU reads it, 18 bits
	// Counters high, sticky flags in the two low bits
	typedef struct packed {
		logic [GUN_CNT_W-1:0] hit_count;
		logic [GUN_CNT_W-1:0] shot_count;
		logic                 hit_flag;
		logic                 shot_flag;
	} gun_status_t;

endpackage

`default_nettype wire

// ==== gun_input_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "memory_map_config.svh"

module gun_input_sync
	import mm_gun_pkg::*;
(
	input  logic                    a_clk,
	input  logic                    rst_n,
	input  logic [`MM_NUM_GUNS-1:0] trigger,
	input  logic [`MM_NUM_GUNS-1:0] sens,
	output gun_pins_t               pins [`MM_NUM_GUNS]
);

	// First stage may go metastable
	logic [`MM_NUM_GUNS-1:0] trig_meta;
	logic [`MM_NUM_GUNS-1:0] sens_meta;

	// Second stage, safe to use
	logic [`MM_NUM_GUNS-1:0] trig_sync;
	logic [`MM_NUM_GUNS-1:0] sens_sync;

	// Two flops per pin, all pins in parallel
	always_ff @(posedge a_clk) begin
		if (!rst_n) begin
			trig_meta <= '0;
			sens_meta <= '0;
			trig_sync <= '0;
			sens_sync <= '0;
		end else begin
			trig_meta <= trigger;
			sens_meta <= sens;
			trig_sync <= trig_meta;
			sens_sync <= sens_meta;
		end
	end

	// Regroup bits into one struct per gun
	for (genvar g = 0; g < `MM_NUM_GUNS; g++) begin : gen_pins
		assign pins[g].trigger = trig_sync[g];
		assign pins[g].sens    = sens_sync[g];
	end

endmodule

`default_nettype wire

// ==== gun_channel.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "memory_map_config.svh"

module gun_channel
	import mm_gun_pkg::*;
(
	input  logic        a_clk,
	input  logic        rst_n,
	input  gun_pins_t   pins,
	input  logic        clear,
	output gun_event_t  evt,
	output gun_status_t status
);

	// Counter holds the remaining window edges
	localparam int WIN_W = $clog2(`MM_HIT_WINDOW + 1);

	logic             trig_prev;
	logic [WIN_W-1:0] win_cnt;
	logic             win_open;
	logic             shot_d;
	logic             hit_d;

	////////////////////////////////////////////////////////////////////////////
	// Edge detect and hit window
	////////////////////////////////////////////////////////////////////////////

	assign win_open = (win_cnt != '0);

	// Rising trigger, dropped while a window is still open
	assign shot_d = pins.trigger & ~trig_prev & ~win_open;

	// Sensor only counts inside the window
	assign hit_d = pins.sens & win_open;

	always_ff @(posedge a_clk) begin
		if (!rst_n) begin
			trig_prev <= 1'b0;
			win_cnt   <= '0;
			evt       <= '0;
		end else begin
			trig_prev <= pins.trigger;
			evt.shot  <= shot_d;
			evt.hit   <= hit_d;
			// Load on shot, close early on the first hit
			if (shot_d)
				win_cnt <= WIN_W'(`MM_HIT_WINDOW);
			else if (hit_d)
				win_cnt <= '0;
			else if (win_open)
				win_cnt <= win_cnt - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Counters and sticky flags
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge a_clk) begin
		if (!rst_n) begin
			status <= '0;
		end else begin
			// Counters wrap, never cleared by the CPU
			if (shot_d)
				status.shot_count <= status.shot_count + 1'b1;
			if (hit_d)
				status.hit_count <= status.hit_count + 1'b1;
			// Set beats clear in the same cycle
			if (shot_d)
				status.shot_flag <= 1'b1;
			else if (clear)
				status.shot_flag <= 1'b0;
			if (hit_d)
				status.hit_flag <= 1'b1;
			else if (clear)
				status.hit_flag <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== io_register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "memory_map_config.svh"

module io_register_file
	import mm_bus_pkg::*;
	import mm_gun_pkg::*;
(
	input  logic                    a_clk,
	input  logic                    rst_n,
	input  cpu_req_t                req,
	input  gun_status_t             status [`MM_NUM_GUNS],
	output logic [`MM_NUM_GUNS-1:0] clear,
	output logic [`MM_DATA_W-1:0]   io_rdata,
	output logic [`MM_RAND_W-1:0]   rand_out
);

	// Feedback taps, polynomial x^10 + x^7 + 1
	localparam int TAP_A = 10;
	localparam int TAP_B = 7;

	localparam logic [`MM_RAND_W-1:0] SEED = `MM_LFSR_SEED;

	// Zero pad from random width up to the data word
	localparam int PAD_W = `MM_DATA_W - `MM_RAND_W;

	logic                  io_hit;
	logic                  io_wr;
	logic [`MM_DATA_W-1:0] rdata_d;
	logic                  lfsr_fb;

	////////////////////////////////////////////////////////////////////////////
	// Page decode and clear strobes
	////////////////////////////////////////////////////////////////////////////

	// Upper address byte picks the I/O page
	assign io_hit = (req.addr.io.page == `MM_IO_PAGE);
	assign io_wr  = req.wr & io_hit;

	// Any write to a status code clears that gun's flags
	// Write data itself is ignored
	assign clear[0] = io_wr & (req.addr.io.reg_sel == SEL_GUN0);
	assign clear[1] = io_wr & (req.addr.io.reg_sel == SEL_GUN1);

	////////////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////////////

	// Values as they stand at the sampling edge
	always_comb begin
		rdata_d = '0;
		if (io_hit) begin
			case (req.addr.io.reg_sel)
				SEL_GUN0: rdata_d = status[0];
				SEL_GUN1: rdata_d = status[1];
				SEL_RAND: rdata_d = {{PAD_W{1'b0}}, rand_out};
				default:  rdata_d = '0;
			endcase
		end
	end

	// One cycle read latency, matches the RAM
	always_ff @(posedge a_clk) begin
		if (!rst_n)
			io_rdata <= '0;
		else
			io_rdata <= rdata_d;
	end

	////////////////////////////////////////////////////////////////////////////
	// Random number generator
	////////////////////////////////////////////////////////////////////////////

	// Fibonacci form, shifts toward the MSB
	assign lfsr_fb = rand_out[TAP_A-1] ^ rand_out[TAP_B-1];

	// Sits at the seed in reset, steps every cycle after
	always_ff @(posedge a_clk) begin
		if (!rst_n)
			rand_out <= SEED;
		else
			rand_out <= {rand_out[`MM_RAND_W-2:0], lfsr_fb};
	end

endmodule

`default_nettype wire

// ==== dual_port_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "memory_map_config.svh"

module dual_port_ram (
	input  logic                  a_clk,
	input  logic                  rst_n,
	input  logic                  a_wr,
	input  logic [`MM_RAM_AW-1:0] a_addr,
	input  logic [`MM_DATA_W-1:0] a_din,
	output logic [`MM_DATA_W-1:0] a_dout,
	input  logic                  b_we,
	input  logic [`MM_RAM_AW-1:0] b_addr,
	input  logic [`MM_DATA_W-1:0] b_din,
	output logic [`MM_DATA_W-1:0] b_dout
);

	localparam int DEPTH = 2 ** `MM_RAM_AW;

	// Storage array, infers block RAM
	logic [`MM_DATA_W-1:0] mem [DEPTH];

	// Both write ports on the one clock
	// Same address from both ports in one cycle is undefined
	always_ff @(posedge a_clk) begin
		if (a_wr)
			mem[a_addr] <= a_din;
		if (b_we)
			mem[b_addr] <= b_din;
	end

	// Read-first, old word comes back on a same-cycle write
	// Output registers held at zero in reset
	always_ff @(posedge a_clk) begin
		if (!rst_n) begin
			a_dout <= '0;
			b_dout <= '0;
		end else begin
			a_dout <= mem[a_addr];
			b_dout <= mem[b_addr];
		end
	end

endmodule

`default_nettype wire

// ==== memory_map.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "memory_map_config.svh"

module memory_map
	import mm_bus_pkg::*;
	import mm_gun_pkg::*;
(
	input  logic                  a_clk,
	input  logic                  rst_n,
	// Port a, video or loader side
	input  logic                  a_wr,
	input  logic [`MM_RAM_AW-1:0] a_addr,
	input  logic [`MM_DATA_W-1:0] a_din,
	output logic [`MM_DATA_W-1:0] a_dout,
	// Port b, CPU side
	input  logic                  b_wr,
	input  logic [`MM_CPU_AW-1:0] b_addr,
	input  logic [`MM_DATA_W-1:0] b_din,
	output logic [`MM_DATA_W-1:0] b_dout,
	// Gun pins, asynchronous
	input  logic                  p1_trigger,
	input  logic                  p1_sens,
	input  logic                  p2_trigger,
	input  logic                  p2_sens,
	output logic                  p1_shot,
	output logic                  p1_hit,
	output logic                  p2_shot,
	output logic                  p2_hit,
	output logic [`MM_RAND_W-1:0] rand_out
);

	cpu_req_t                b_req;
	logic                    b_ram_sel;
	logic                    b_ram_sel_q;
	logic                    b_ram_we;
	logic [`MM_DATA_W-1:0]   ram_b_dout;
	logic [`MM_DATA_W-1:0]   io_rdata;
	logic [`MM_NUM_GUNS-1:0] clear;
	gun_pins_t               pins   [`MM_NUM_GUNS];
	gun_event_t              evt    [`MM_NUM_GUNS];
	gun_status_t             status [`MM_NUM_GUNS];

	////////////////////////////////////////////////////////////////////////////
	// Port b decode
	////////////////////////////////////////////////////////////////////////////

	assign b_req.wr   = b_wr;
	assign b_req.addr = b_addr;
	assign b_req.din  = b_din;

	// Region 00 is the RAM, the rest goes to the I/O side
	assign b_ram_sel = (b_req.addr.ram.region == '0);
	assign b_ram_we  = b_wr & b_ram_sel;

	// Region select delayed to line up with the read data
	always_ff @(posedge a_clk) begin
		if (!rst_n)
			b_ram_sel_q <= 1'b0;
		else
			b_ram_sel_q <= b_ram_sel;
	end

	// I/O data already zero for unmapped addresses
	assign b_dout = b_ram_sel_q ? ram_b_dout : io_rdata;

	////////////////////////////////////////////////////////////////////////////
	// Gun channels
	////////////////////////////////////////////////////////////////////////////

	gun_input_sync u_gun_input_sync (
		.a_clk   (a_clk),
		.rst_n   (rst_n),
		.trigger ({p2_trigger, p1_trigger}),
		.sens    ({p2_sens, p1_sens}),
		.pins    (pins)
	);

	for (genvar g = 0; g < `MM_NUM_GUNS; g++) begin : gen_gun
		gun_channel u_gun_channel (
			.a_clk  (a_clk),
			.rst_n  (rst_n),
			.pins   (pins[g]),
			.clear  (clear[g]),
			.evt    (evt[g]),
			.status (status[g])
		);
	end

	// Player 1 is gun 0
	assign p1_shot = evt[0].shot;
	assign p1_hit  = evt[0].hit;
	assign p2_shot = evt[1].shot;
	assign p2_hit  = evt[1].hit;

	io_register_file u_io_register_file (
		.a_clk    (a_clk),
		.rst_n    (rst_n),
		.req      (b_req),
		.status   (status),
		.clear    (clear),
		.io_rdata (io_rdata),
		.rand_out (rand_out)
	);

	// Shared RAM, port b sees only the word index
	dual_port_ram u_dual_port_ram (
		.a_clk  (a_clk),
		.rst_n  (rst_n),
		.a_wr   (a_wr),
		.a_addr (a_addr),
		.a_din  (a_din),
		.a_dout (a_dout),
		.b_we   (b_ram_we),
		.b_addr (b_req.addr.ram.word),
		.b_din  (b_din),
		.b_dout (ram_b_dout)
	);

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic a_clk,
	output logic rst_n
);

	// 100 ns period
	initial begin
		a_clk = 1'b0;
		forever #50 a_clk = ~a_clk;
	end

	// Reset held low over the first 3 rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge a_clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== memory_map_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "memory_map_config.svh"

module memory_map_assertions (
	input logic                  a_clk,
	input logic                  rst_n,
	input logic                  p1_shot,
	input logic                  p1_hit,
	input logic                  p2_shot,
	input logic                  p2_hit,
	input logic [`MM_DATA_W-1:0] a_dout,
	input logic [`MM_DATA_W-1:0] b_dout,
	input logic [`MM_RAND_W-1:0] rand_out
);

	// Count of failed properties
	int unsigned fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// Pulse widths
	////////////////////////////////////////////////////////////////////////////

	// Window is longer than one cycle, so no back to back shots
	p1_shot_single: assert property (@(posedge a_clk) disable iff (!rst_n)
		p1_shot |=> !p1_shot) else begin
		$error("p1_shot wider than one cycle");
		fail_count++;
	end
	p2_shot_single: assert property (@(posedge a_clk) disable iff (!rst_n)
		p2_shot |=> !p2_shot) else begin
		$error("p2_shot wider than one cycle");
		fail_count++;
	end

	// First hit closes the window
	p1_hit_single: assert property (@(posedge a_clk) disable iff (!rst_n)
		p1_hit |=> !p1_hit) else begin
		$error("p1_hit wider than one cycle");
		fail_count++;
	end
	p2_hit_single: assert property (@(posedge a_clk) disable iff (!rst_n)
		p2_hit |=> !p2_hit) else begin
		$error("p2_hit wider than one cycle");
		fail_count++;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reset state
	////////////////////////////////////////////////////////////////////////////

	// Everything quiet one edge after reset is sampled
	reset_quiet: assert property (@(posedge a_clk)
		!rst_n |=> (!p1_shot && !p1_hit && !p2_shot && !p2_hit
			&& a_dout == '0 && b_dout == '0))
		else begin
			$error("Outputs not cleared by reset");
			fail_count++;
		end

	// LFSR parked on its seed
	reset_seed: assert property (@(posedge a_clk)
		!rst_n |=> (rand_out == `MM_RAND_W'(`MM_LFSR_SEED)))
		else begin
			$error("LFSR not at seed after reset");
			fail_count++;
		end

endmodule

`default_nettype wire

// ==== memory_map_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "memory_map_config.svh"

module memory_map_tb;

	localparam int RAM_USED = 64;
	localparam int RAND_CYCLES = 3000;

	logic                  a_clk;
	logic                  rst_n;
	logic                  a_wr;
	logic [`MM_RAM_AW-1:0] a_addr;
	logic [`MM_DATA_W-1:0] a_din;
	logic [`MM_DATA_W-1:0] a_dout;
	logic                  b_wr;
	logic [`MM_CPU_AW-1:0] b_addr;
	logic [`MM_DATA_W-1:0] b_din;
	logic [`MM_DATA_W-1:0] b_dout;
	logic                  p1_trigger;
	logic                  p1_sens;
	logic                  p2_trigger;
	logic                  p2_sens;
	logic                  p1_shot;
	logic                  p1_hit;
	logic                  p2_shot;
	logic                  p2_hit;
	logic [`MM_RAND_W-1:0] rand_out;

	// Values for the next drive edge
	logic                  nx_a_wr;
	logic [`MM_RAM_AW-1:0] nx_a_addr;
	logic [`MM_DATA_W-1:0] nx_a_din;
	logic                  nx_b_wr;
	logic [`MM_CPU_AW-1:0] nx_b_addr;
	logic [`MM_DATA_W-1:0] nx_b_din;
	logic [3:0]            nx_pins;

	integer seed = 22699;
	int     errors = 0;
	string  test_name = "reset";

	// Held gun pin levels, order p1 trigger, p1 sens, p2 trigger, p2 sens
	int hold_left [4];

	////////////////////////////////////////////////////////////////////////////
	// Reference model state
	////////////////////////////////////////////////////////////////////////////

	logic [1:0]            m_trig_meta, m_trig_sync, m_sens_meta, m_sens_sync;
	logic [1:0]            m_trig_prev, m_shot, m_hit, m_shot_flag, m_hit_flag;
	int                    m_win [2];
	logic [7:0]            m_shot_cnt [2];
	logic [7:0]            m_hit_cnt [2];
	logic [`MM_RAND_W-1:0] m_lfsr;
	logic [`MM_DATA_W-1:0] m_ram [RAM_USED];
	logic                  m_ram_ok [RAM_USED];
	logic [`MM_DATA_W-1:0] m_a_dout, m_b_ram, m_io;
	logic                  m_a_ok, m_b_ok, m_b_sel;

	tb_clock_gen u_tb_clock_gen (
		.a_clk (a_clk),
		.rst_n (rst_n)
	);

	memory_map u_memory_map (.*);

	bind memory_map memory_map_assertions u_memory_map_assertions (.*);

	// Status word layout, counters high and flags low
	function automatic logic [`MM_DATA_W-1:0] status_word(int g);
		return {m_hit_cnt[g], m_shot_cnt[g], m_hit_flag[g], m_shot_flag[g]};
	endfunction

	// One rising edge of the model, inputs as sampled at that edge
	task automatic model_step();
		logic [1:0]            shot_d;
		logic [1:0]            hit_d;
		logic [1:0]            clr;
		logic [`MM_DATA_W-1:0] io_d;
		logic                  io_page;
		io_page = (b_addr[15:8] == `MM_IO_PAGE);
		io_d = '0;
		if (io_page && b_addr[7:0] == 8'h00)
			io_d = status_word(0);
		if (io_page && b_addr[7:0] == 8'h01)
			io_d = status_word(1);
		if (io_page && b_addr[7:0] == 8'h10)
			io_d = {{(`MM_DATA_W-`MM_RAND_W){1'b0}}, m_lfsr};
		for (int g = 0; g < 2; g++) begin
			clr[g]    = b_wr && io_page && b_addr[7:0] == 8'(g);
			shot_d[g] = m_trig_sync[g] && !m_trig_prev[g] && m_win[g] == 0;
			hit_d[g]  = m_sens_sync[g] && m_win[g] != 0;
		end
		// Port reads see the old word
		m_a_dout = m_ram[a_addr[5:0]];
		m_a_ok   = m_ram_ok[a_addr[5:0]];
		m_b_sel  = (b_addr[15:14] == 2'b00);
		m_b_ram  = m_ram[b_addr[5:0]];
		m_b_ok   = !m_b_sel || m_ram_ok[b_addr[5:0]];
		// Array writes ignore reset
		if (a_wr) begin
			m_ram[a_addr[5:0]]    = a_din;
			m_ram_ok[a_addr[5:0]] = 1'b1;
		end
		if (b_wr && m_b_sel) begin
			m_ram[b_addr[5:0]]    = b_din;
			m_ram_ok[b_addr[5:0]] = 1'b1;
		end
		if (!rst_n) begin
			{m_trig_meta, m_trig_sync, m_sens_meta, m_sens_sync} = '0;
			{m_trig_prev, m_shot, m_hit, m_shot_flag, m_hit_flag} = '0;
			m_win      = '{0, 0};
			m_shot_cnt = '{8'h00, 8'h00};
			m_hit_cnt  = '{8'h00, 8'h00};
			m_lfsr     = `MM_RAND_W'(`MM_LFSR_SEED);
			m_a_dout   = '0;
			m_a_ok     = 1'b1;
			m_b_sel    = 1'b0;
			m_io       = '0;
			m_b_ok     = 1'b1;
		end else begin
			for (int g = 0; g < 2; g++) begin
				m_trig_prev[g] = m_trig_sync[g];
				// Window spans the 16 edges after the shot edge
				if (shot_d[g])
					m_win[g] = `MM_HIT_WINDOW;
				else if (hit_d[g])
					m_win[g] = 0;
				else if (m_win[g] != 0)
					m_win[g]--;
				if (shot_d[g])
					m_shot_cnt[g]++;
				if (hit_d[g])
					m_hit_cnt[g]++;
				// Set wins over clear
				m_shot_flag[g] = shot_d[g] || (m_shot_flag[g] && !clr[g]);
				m_hit_flag[g]  = hit_d[g] || (m_hit_flag[g] && !clr[g]);
			end
			m_shot      = shot_d;
			m_hit       = hit_d;
			m_trig_sync = m_trig_meta;
			m_sens_sync = m_sens_meta;
			m_trig_meta = {p2_trigger, p1_trigger};
			m_sens_meta = {p2_sens, p1_sens};
			m_io        = io_d;
			m_lfsr      = {m_lfsr[`MM_RAND_W-2:0], m_lfsr[9] ^ m_lfsr[6]};
		end
	endtask

	task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
		assert (exp === act) else begin
			errors++;
			$display("ERROR %s %s expected %0h actual %0h", test_name, what, exp, act);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout while waiting for %s in test %s", what, test_name);
		$display("Regression failed");
		$fatal(1);
	endtask

	// Outputs settle well before the falling edge
	task automatic check_outputs();
		check_value("p1_shot", 32'(m_shot[0]), 32'(p1_shot));
		check_value("p1_hit", 32'(m_hit[0]), 32'(p1_hit));
		check_value("p2_shot", 32'(m_shot[1]), 32'(p2_shot));
		check_value("p2_hit", 32'(m_hit[1]), 32'(p2_hit));
		check_value("rand_out", 32'(m_lfsr), 32'(rand_out));
		if (m_a_ok)
			check_value("a_dout", 32'(m_a_dout), 32'(a_dout));
		if (m_b_ok)
			check_value("b_dout", 32'(m_b_sel ? m_b_ram : m_io), 32'(b_dout));
	endtask

	// Model and drive on the rising edge, check on the falling edge
	task automatic step_cycle();
		@(posedge a_clk);
		model_step();
		a_wr       <= nx_a_wr;
		a_addr     <= nx_a_addr;
		a_din      <= nx_a_din;
		b_wr       <= nx_b_wr;
		b_addr     <= nx_b_addr;
		b_din      <= nx_b_din;
		p1_trigger <= nx_pins[0];
		p1_sens    <= nx_pins[1];
		p2_trigger <= nx_pins[2];
		p2_sens    <= nx_pins[3];
		@(negedge a_clk);
		check_outputs();
	endtask

	// Pin levels held for 1 to 40 cycles, sensor high less often
	task automatic pick_gun_pins();
		for (int i = 0; i < 4; i++) begin
			if (hold_left[i] == 0) begin
				hold_left[i] = $unsigned($random(seed)) % 40 + 1;
				if (i % 2 == 0)
					nx_pins[i] = $random(seed);
				else
					nx_pins[i] = ($unsigned($random(seed)) % 3 == 0);
			end
			hold_left[i]--;
		end
	endtask

	// Port b mixes RAM, I/O page and unmapped space
	task automatic pick_bus_request();
		int kind;
		kind      = $unsigned($random(seed)) % 6;
		nx_a_wr   = $random(seed);
		nx_a_addr = `MM_RAM_AW'($unsigned($random(seed)) % RAM_USED);
		nx_a_din  = `MM_DATA_W'($random(seed));
		nx_b_wr   = ($unsigned($random(seed)) % 4 == 0);
		nx_b_din  = `MM_DATA_W'($random(seed));
		if (kind < 3) begin
			nx_b_addr = 16'($unsigned($random(seed)) % RAM_USED);
		end else if (kind < 5) begin
			case ($unsigned($random(seed)) % 4)
				0: nx_b_addr = 16'hF000;
				1: nx_b_addr = 16'hF001;
				2: nx_b_addr = 16'hF010;
				default: nx_b_addr = {8'hF0, 8'($random(seed))};
			endcase
		end else begin
			// Unmapped regions, low word bits inside the tracked range
			nx_b_addr = {2'($unsigned($random(seed)) % 3 + 1), 8'h00,
				6'($unsigned($random(seed)) % RAM_USED)};
		end
		// Keep both ports off one word in a write cycle
		if (nx_a_wr && nx_b_addr[15:14] == 2'b00 && nx_b_addr[5:0] == nx_a_addr[5:0])
			nx_b_wr = 1'b0;
	endtask

	task automatic idle_bus();
		nx_a_wr   = 1'b0;
		nx_a_addr = '0;
		nx_a_din  = '0;
		nx_b_wr   = 1'b0;
		nx_b_addr = 16'hF0FF;
		nx_b_din  = '0;
	endtask

	// Hard limit on the whole run
	initial begin
		#(100ns * 20000);
		report_timeout("the end of the run");
	end

	initial begin
		int cnt;
		{a_wr, b_wr, p1_trigger, p1_sens, p2_trigger, p2_sens} = '0;
		a_addr = '0;
		a_din  = '0;
		b_addr = 16'hF0FF;
		b_din  = '0;
		nx_pins = '0;
		hold_left = '{0, 0, 0, 0};
		m_ram_ok = '{default: 1'b0};
		idle_bus();

		// Reset release, then read both status words and the LFSR
		cnt = 0;
		while (rst_n !== 1'b1) begin
			if (cnt >= 20)
				report_timeout("reset release");
			step_cycle();
			cnt++;
		end
		nx_b_addr = 16'hF000;
		step_cycle();
		nx_b_addr = 16'hF001;
		step_cycle();
		nx_b_addr = 16'hF010;
		step_cycle();
		idle_bus();
		step_cycle();

		// Fill used RAM words, pattern over the whole address
		test_name = "ram_fill";
		for (int i = 0; i < RAM_USED; i++) begin
			nx_a_wr   = 1'b1;
			nx_a_addr = `MM_RAM_AW'(i);
			nx_a_din  = `MM_DATA_W'((i * 18'h2F3) ^ (i << 7) ^ 18'h15A5A);
			step_cycle();
		end
		idle_bus();
		step_cycle();

		// Mixed traffic and gun activity
		test_name = "random_traffic";
		repeat (RAND_CYCLES) begin
			pick_bus_request();
			pick_gun_pins();
			step_cycle();
		end

		// Clean trigger edge after a quiet gap
		test_name = "shot_wait";
		idle_bus();
		nx_pins = '0;
		repeat (60) step_cycle();
		nx_pins[0] = 1'b1;
		cnt = 0;
		step_cycle();
		while (!p1_shot) begin
			if (cnt >= 10)
				report_timeout("p1_shot");
			step_cycle();
			cnt++;
		end
		nx_pins = '0;
		repeat (4) step_cycle();

		if (errors == 0 && u_memory_map.u_memory_map_assertions.fail_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
mm_bus_pkg.sv
mm_gun_pkg.sv
gun_input_sync.sv
gun_channel.sv
io_register_file.sv
dual_port_ram.sv
memory_map.sv
tb_clock_gen.sv
memory_map_assertions.sv
memory_map_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then judge the run by its log

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module memory_map_tb \
	-f list.f -o memory_map_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/memory_map_sim > sim.log 2>&1 || echo "Simulator exited with an error status"

cat sim.log
grep -q "Regression failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Regression passed" sim.log || { echo "No pass line in sim.log"; exit 1; }
echo "Simulation OK"
